/* verilog/decodeQueuePkg.sv */
package decodeQueuePkg;

  localparam int MaxFetchWidth    = 8;  // Widest bundle fetch can ever hand over.
  localparam int MaxDispatchWidth = 4;  // Widest group the back end can ever take.

  // Opcode 0 selects the register format and every other opcode carries an immediate.
  localparam logic [5:0] OpRType       = 6'd0;
  localparam logic [5:0] OpBranchFirst = 6'd4;  // Lowest branch opcode.
  localparam logic [5:0] OpBranchLast  = 6'd7;  // Highest branch opcode, inclusive.

  // Register format of a 32-bit instruction word.
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeInst_t;

  // Immediate format of the same word. Opcode, rs and rt share their bits with the R view.
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeInst_t;

  // One fetched word, which the decoder reads in whichever format its opcode selects.
  typedef union packed {
    rTypeInst_t  r;
    iTypeInst_t  i;
    logic [31:0] raw;
  } instWord_u;

  // Decoded packet as it sits in the instruction buffer (71 bits).
  typedef struct packed {
    logic [31:0] pc;
    logic [5:0]  opcode;
    logic [4:0]  srcA;
    logic [4:0]  srcB;
    logic [4:0]  dest;      // Zero when the instruction writes no register.
    logic [15:0] imm;
    logic        isBranch;
    logic        hasImm;
  } decodedInst_t;

  typedef struct packed {
    logic [31:0]                     pc;     // PC of slot 0.
    instWord_u [MaxFetchWidth-1:0]   words;
  } fetchBundle_t;

  typedef struct packed {
    logic [MaxFetchWidth-1:0]         valid;
    decodedInst_t [MaxFetchWidth-1:0] packets;
  } decodeBundle_t;

  typedef struct packed {
    decodedInst_t [MaxDispatchWidth-1:0] packets;  // Packet 0 is the oldest.
  } dispatchBundle_t;

endpackage

/* verilog/multiPortRam.sv */
`timescale 1ns/1ps

// Packet storage for the instruction buffer.
// Every write port is a synchronous port and every read port is a plain
// combinational read, so the head group is visible in the same cycle.
module multiPortRam #(
  parameter int Depth      = 32,
  parameter int AddrWidth  = 5,
  parameter int WritePorts = 8,
  parameter int ReadPorts  = 4
) (
  input  logic                                          clk,
  input  logic [WritePorts-1:0]                         we_i,
  input  logic [WritePorts-1:0][AddrWidth-1:0]          wrAddr_i,
  input  decodeQueuePkg::decodedInst_t [WritePorts-1:0] wrData_i,
  input  logic [ReadPorts-1:0][AddrWidth-1:0]           rdAddr_i,
  output decodeQueuePkg::decodedInst_t [ReadPorts-1:0]  rdData_o
);

  decodeQueuePkg::decodedInst_t mem [Depth];  // The entries themselves.

  // All write ports update on the same edge.
  // The loop runs from port 0 upward, so the last matching port is the
  // one that sticks when two ports name the same entry.
  // The buffer gives every valid slot its own address, so that case
  // does not come up in normal operation.
  always_ff @(posedge clk) begin
    for (int p = 0; p < WritePorts; p++) begin
      if (we_i[p]) begin
        mem[wrAddr_i[p]] <= wrData_i[p];  // Port p writes its packet.
      end
    end
  end

  // Read ports have no register in the path.
  always_comb begin
    for (int p = 0; p < ReadPorts; p++) begin
      rdData_o[p] = mem[rdAddr_i[p]];  // Entry at this port's address.
    end
  end

endmodule

/* verilog/preDecoder.sv */
`timescale 1ns/1ps

// Decode stage between fetch and the instruction buffer.
// Each slot of the incoming bundle is split into a decoded packet in
// plain logic, and the whole bundle is captured on the next edge.
// The stage never stalls by itself. Fetch holds its valid low while the
// buffer asks for a fetch stall.
module preDecoder #(
  parameter int FetchWidth = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 flush_i,
  input  logic                                 fetchValid_i,
  input  logic [decodeQueuePkg::MaxFetchWidth-1:0] fetchVector_i,
  input  decodeQueuePkg::fetchBundle_t         fetch_i,
  output decodeQueuePkg::decodeBundle_t        decoded_o
);

  logic [decodeQueuePkg::MaxFetchWidth-1:0]                        validNext;
  decodeQueuePkg::decodedInst_t [decodeQueuePkg::MaxFetchWidth-1:0] packetsNext;

  logic [decodeQueuePkg::MaxFetchWidth-1:0]                        validQ;    // Registered slot mask.
  decodeQueuePkg::decodedInst_t [decodeQueuePkg::MaxFetchWidth-1:0] packetsQ;  // Registered packets.

  for (genvar s = 0; s < decodeQueuePkg::MaxFetchWidth; s++) begin : gSlot
    decodeQueuePkg::instWord_u    word;
    decodeQueuePkg::decodedInst_t pkt;
    logic                         isRType;
    logic                         isBranch;

    assign word     = fetch_i.words[s];
    assign isRType  = (word.r.opcode == decodeQueuePkg::OpRType);  // Opcode sits in the same bits.
    assign isBranch = (word.i.opcode >= decodeQueuePkg::OpBranchFirst) &&
                      (word.i.opcode <= decodeQueuePkg::OpBranchLast);

    always_comb begin
      pkt.pc       = fetch_i.pc + 32'(s * 4);  // Slots are consecutive words.
      pkt.opcode   = word.i.opcode;  // Opcode and rs occupy the same bits in both views.
      pkt.srcA     = word.i.rs;
      pkt.isBranch = isBranch;
      pkt.hasImm   = !isRType;
      if (isRType) begin
        // Register format reads two sources and writes rd.
        pkt.srcB   = word.r.rt;
        pkt.dest   = word.r.rd;
        pkt.imm    = '0;  // No immediate field in this format.
      end else begin
        pkt.srcB   = '0;
        // A branch compares registers and writes none, other immediates write rt.
        pkt.dest   = isBranch ? 5'd0 : word.i.rt;
        pkt.imm    = word.i.imm;
      end
    end

    // Slots beyond the configured width never carry an instruction.
    assign validNext[s]   = (s < FetchWidth) ? (fetchValid_i && fetchVector_i[s]) : 1'b0;
    assign packetsNext[s] = pkt;
  end

  // The valid mask is control state and is cleared by reset or by a flush.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      validQ <= '0;
    end else begin
      validQ <= validNext;  // Captured every cycle, even an empty bundle.
    end
  end

  // Packet payload only matters where the mask is set.
  always_ff @(posedge clk) begin
    packetsQ <= packetsNext;
  end

  assign decoded_o = '{valid: validQ, packets: packetsQ};

endmodule

/* verilog/instructionBuffer.sv */
`timescale 1ns/1ps

// Circular instruction queue between decode and dispatch.
// Valid slots of each decoded bundle are packed into consecutive entries at
// the tail. Whole groups of DispatchWidth leave from the head when the back
// end is not stalling.
module instructionBuffer #(
  parameter int QueueDepth    = 32,
  parameter int FetchWidth    = 8,
  parameter int DispatchWidth = 4
) (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            flush_i,
  input  logic                            stall_i,
  input  decodeQueuePkg::decodeBundle_t   decoded_i,
  output logic                            stallFetch_o,
  output logic                            dispatchReady_o,
  output decodeQueuePkg::dispatchBundle_t dispatch_o,
  output logic [2:0]                      branchCount_o
);

  localparam int AddrWidth    = $clog2(QueueDepth);
  localparam int SlotCntWidth = $clog2(FetchWidth + 1);  // Holds 0 up to FetchWidth.

  logic [AddrWidth-1:0] headPtr;   // Oldest entry.
  logic [AddrWidth-1:0] tailPtr;   // Next free entry.
  logic [AddrWidth:0]   count;     // One extra bit so a full queue is representable.
  logic [AddrWidth:0]   countNext;

  logic [SlotCntWidth-1:0] writeCount;  // Valid slots in the bundle leaving decode.
  logic                    doDispatch;

  logic [FetchWidth-1:0]                         we;
  logic [FetchWidth-1:0][AddrWidth-1:0]          wrAddr;
  decodeQueuePkg::decodedInst_t [FetchWidth-1:0] wrData;
  logic [DispatchWidth-1:0][AddrWidth-1:0]          rdAddr;
  decodeQueuePkg::decodedInst_t [DispatchWidth-1:0] rdData;

  multiPortRam #(
    .Depth     (QueueDepth),
    .AddrWidth (AddrWidth),
    .WritePorts(FetchWidth),
    .ReadPorts (DispatchWidth)
  ) ram (
    .clk     (clk),
    .we_i    (we),
    .wrAddr_i(wrAddr),
    .wrData_i(wrData),
    .rdAddr_i(rdAddr),
    .rdData_o(rdData)
  );

  // A running prefix count of the valid mask gives each valid slot its offset from the tail.
  // Holes in the mask therefore leave no holes in the queue.
  always_comb begin : writePorts
    logic [SlotCntWidth-1:0] running;
    running = '0;
    for (int s = 0; s < FetchWidth; s++) begin
      we[s]     = decoded_i.valid[s];  // No gate here. The fetch stall keeps room free.
      wrAddr[s] = tailPtr + AddrWidth'(running);
      wrData[s] = decoded_i.packets[s];
      running   = running + SlotCntWidth'(decoded_i.valid[s]);
    end
    writeCount = running;
  end

  // A group is ready once a full DispatchWidth of entries is waiting.
  assign dispatchReady_o = (count >= (AddrWidth + 1)'(DispatchWidth));
  assign doDispatch      = dispatchReady_o && !stall_i;  // Group taken on this edge.

  // Fetch stops while fewer than two bundles of room remain.
  // One bundle may still be in flight in the decode register when the stall rises.
  assign stallFetch_o = (count > (AddrWidth + 1)'(QueueDepth - 2 * FetchWidth));

  always_comb begin
    countNext = count + (AddrWidth + 1)'(writeCount);
    if (doDispatch) begin
      countNext = countNext - (AddrWidth + 1)'(DispatchWidth);
    end
  end

  // The pointers wrap on their own because QueueDepth is a power of two.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      tailPtr <= tailPtr + AddrWidth'(writeCount);
      if (doDispatch) begin
        headPtr <= headPtr + AddrWidth'(DispatchWidth);  // Moves only on a real dispatch.
      end
      count <= countNext;
    end
  end

  // Read the head group and count the branches in it.
  // Unused group slots stay zero when DispatchWidth is below the maximum.
  always_comb begin
    dispatch_o    = '0;
    branchCount_o = '0;
    for (int r = 0; r < DispatchWidth; r++) begin
      rdAddr[r]             = headPtr + AddrWidth'(r);
      dispatch_o.packets[r] = rdData[r];
      branchCount_o         = branchCount_o + 3'(rdData[r].isBranch);
    end
  end

endmodule

/* verilog/decodeFrontEnd.sv */
`timescale 1ns/1ps

// Front-end slice from the fetch bundle to the dispatch group.
// The pre-decoder feeds the instruction buffer directly. The sizes are set here
// and handed down to both stages.
module decodeFrontEnd #(
  parameter int QueueDepth    = 32,  // Power of two, at least 2*FetchWidth + DispatchWidth.
  parameter int FetchWidth    = 8,
  parameter int DispatchWidth = 4
) (
  input  logic                                     clk,
  input  logic                                     rst_i,
  input  logic                                     flush_i,
  input  logic                                     stall_i,
  input  logic                                     fetchValid_i,
  input  logic [decodeQueuePkg::MaxFetchWidth-1:0] fetchVector_i,
  input  decodeQueuePkg::fetchBundle_t             fetch_i,
  output logic                                     stallFetch_o,
  output logic                                     dispatchReady_o,
  output decodeQueuePkg::dispatchBundle_t          dispatch_o,
  output logic [2:0]                               branchCount_o
);

  decodeQueuePkg::decodeBundle_t decoded;  // Decode register output.

  preDecoder #(
    .FetchWidth(FetchWidth)
  ) decoder (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .fetchValid_i (fetchValid_i),
    .fetchVector_i(fetchVector_i),
    .fetch_i      (fetch_i),
    .decoded_o    (decoded)
  );

  instructionBuffer #(
    .QueueDepth   (QueueDepth),
    .FetchWidth   (FetchWidth),
    .DispatchWidth(DispatchWidth)
  ) buffer (
    .clk            (clk),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .stall_i        (stall_i),
    .decoded_i      (decoded),
    .stallFetch_o   (stallFetch_o),
    .dispatchReady_o(dispatchReady_o),
    .dispatch_o     (dispatch_o),
    .branchCount_o  (branchCount_o)
  );

endmodule

/* tests/decodeFrontEndTb.sv */
`timescale 1ns/1ps

module decodeFrontEndTb;

  localparam int QueueDepth    = 32;  // Default sizes of the DUT.
  localparam int FetchWidth    = 8;
  localparam int DispatchWidth = 4;

  // Cycle budget of each test, and a run limit of twice their sum.
  localparam int ResetCycles  = 20;
  localparam int OrderCycles  = 100;
  localparam int SparseCycles = 120;
  localparam int BranchCycles = 80;
  localparam int StallCycles  = 60;
  localparam int FlushCycles  = 60;
  localparam int CycleLimit   = 2 * (ResetCycles + OrderCycles + SparseCycles +
                                     BranchCycles + StallCycles + FlushCycles);

  logic                                     clk;
  logic                                     rst_i;
  logic                                     flush_i;
  logic                                     stall_i;
  logic                                     fetchValid_i;
  logic [decodeQueuePkg::MaxFetchWidth-1:0] fetchVector_i;
  decodeQueuePkg::fetchBundle_t             fetch_i;
  logic                                     stallFetch_o;
  logic                                     dispatchReady_o;
  decodeQueuePkg::dispatchBundle_t          dispatch_o;
  logic [2:0]                               branchCount_o;

  integer      seed;
  int          cycleCount;
  string       testName;
  logic [31:0] pcNext;     // PC of the next bundle that fetch hands over.
  logic        sawStall;

  // Reference model. The queue mirrors the buffer and the pending bundle mirrors decode.
  decodeQueuePkg::decodedInst_t modelQ[$];
  logic [FetchWidth-1:0]        pendValid;
  decodeQueuePkg::decodedInst_t pendPkts [FetchWidth];

  decodeFrontEnd dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .stall_i        (stall_i),
    .fetchValid_i   (fetchValid_i),
    .fetchVector_i  (fetchVector_i),
    .fetch_i        (fetch_i),
    .stallFetch_o   (stallFetch_o),
    .dispatchReady_o(dispatchReady_o),
    .dispatch_o     (dispatch_o),
    .branchCount_o  (branchCount_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period.
  end

  task automatic failRun(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  function automatic string mismatchLine(input string signal, input logic [70:0] expected,
                                         input logic [70:0] actual);
    return $sformatf("ERROR %s: %s expected %h, actual %h", testName, signal, expected, actual);
  endfunction

  // Decode rules applied to the raw word bits, field by field.
  function automatic decodeQueuePkg::decodedInst_t expectedPacket(input logic [31:0] word,
                                                                  input logic [31:0] pc);
    decodeQueuePkg::decodedInst_t pkt;
    logic [5:0]                   opcode;
    logic                         branch;
    opcode = word[31:26];
    branch = (opcode >= decodeQueuePkg::OpBranchFirst) && (opcode <= decodeQueuePkg::OpBranchLast);
    pkt.pc       = pc;
    pkt.opcode   = opcode;
    pkt.srcA     = word[25:21];
    pkt.isBranch = branch;
    pkt.hasImm   = (opcode != decodeQueuePkg::OpRType);
    if (opcode == decodeQueuePkg::OpRType) begin
      pkt.srcB = word[20:16];
      pkt.dest = word[15:11];  // rd.
      pkt.imm  = '0;
    end else begin
      pkt.srcB = '0;
      pkt.dest = branch ? 5'd0 : word[20:16];  // Branches write no register.
      pkt.imm  = word[15:0];
    end
    return pkt;
  endfunction

  // Opcode classes are R format, plain immediates, branches and everything above.
  function automatic logic [31:0] randomWord();
    logic [31:0] bits;
    logic [5:0]  opcode;
    int          kind;
    bits = $random(seed);
    kind = $unsigned($random(seed)) % 4;
    case (kind)
      0:       opcode = 6'd0;
      1:       opcode = 6'(1 + $unsigned($random(seed)) % 3);
      2:       opcode = 6'(4 + $unsigned($random(seed)) % 4);
      default: opcode = 6'(8 + $unsigned($random(seed)) % 56);
    endcase
    return {opcode, bits[25:0]};
  endfunction

  // The model follows the same edge as the DUT and reads only testbench signals.
  always @(posedge clk) begin : refModel
    if (rst_i || flush_i) begin
      modelQ.delete();
      pendValid = '0;  // The bundle in decode is dropped too.
    end else begin
      if (modelQ.size() >= DispatchWidth && !stall_i) begin
        repeat (DispatchWidth) void'(modelQ.pop_front());  // A group leaves.
      end
      for (int s = 0; s < FetchWidth; s++) begin
        if (pendValid[s]) modelQ.push_back(pendPkts[s]);  // Packed in slot order.
      end
      pendValid = fetchValid_i ? fetchVector_i[FetchWidth-1:0] : '0;
      for (int s = 0; s < FetchWidth; s++) begin
        pendPkts[s] = expectedPacket(fetch_i.words[s].raw, fetch_i.pc + 32'(4 * s));
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycleCount++;
    if (cycleCount > CycleLimit) begin
      failRun($sformatf("Timeout: the run did not finish within %0d cycles.", CycleLimit));
    end
  end

  // After a reset or flush edge, both flow-control outputs must be low.
  assert property (@(posedge clk) (rst_i || flush_i) |=> (!stallFetch_o && !dispatchReady_o))
    else failRun(mismatchLine("{stallFetch_o, dispatchReady_o}", 71'b0,
                              71'({$sampled(stallFetch_o), $sampled(dispatchReady_o)})));

  // Compares every output with the model at the falling edge, where all of them are stable.
  task automatic checkOutputs();
    logic       expReady;
    logic       expStall;
    logic [2:0] expBranches;
    expReady    = (modelQ.size() >= DispatchWidth);
    expStall    = (modelQ.size() > QueueDepth - 2 * FetchWidth);
    expBranches = '0;
    assert (dispatchReady_o === expReady)
      else failRun(mismatchLine("dispatchReady_o", 71'(expReady), 71'(dispatchReady_o)));
    assert (stallFetch_o === expStall)
      else failRun(mismatchLine("stallFetch_o", 71'(expStall), 71'(stallFetch_o)));
    if (expReady) begin
      for (int k = 0; k < DispatchWidth; k++) begin
        assert (dispatch_o.packets[k] === modelQ[k])
          else failRun(mismatchLine($sformatf("dispatch_o.packets[%0d]", k), modelQ[k],
                                    dispatch_o.packets[k]));
        if (modelQ[k].opcode >= decodeQueuePkg::OpBranchFirst &&
            modelQ[k].opcode <= decodeQueuePkg::OpBranchLast) begin
          expBranches++;
        end
      end
      assert (branchCount_o === expBranches)
        else failRun(mismatchLine("branchCount_o", 71'(expBranches), 71'(branchCount_o)));
    end
  endtask

  // One cycle of stimulus. Fetch only sends while the buffer allows it.
  task automatic stepCycle(input logic send, input logic [7:0] vector, input logic stall);
    @(negedge clk);
    checkOutputs();
    flush_i       = 1'b0;
    stall_i       = stall;
    fetchValid_i  = send && !stallFetch_o;
    fetchVector_i = vector;
    fetch_i.pc    = pcNext;
    for (int s = 0; s < decodeQueuePkg::MaxFetchWidth; s++) begin
      fetch_i.words[s].raw = randomWord();
    end
    if (fetchValid_i) pcNext = pcNext + 32'd32;  // Next bundle follows on.
  endtask

  task automatic drain();
    while (modelQ.size() >= DispatchWidth || pendValid != '0) begin
      stepCycle(1'b0, 8'h00, 1'b0);
    end
  endtask

  task automatic pulseFlush();
    @(negedge clk);
    checkOutputs();
    flush_i      = 1'b1;
    stall_i      = 1'b0;
    fetchValid_i = !stallFetch_o;  // A bundle in flight that the flush must drop.
  endtask

  initial begin
    seed          = 32'h90cf442e;
    cycleCount    = 0;
    testName      = "reset";
    pcNext        = 32'h0000_1000;
    sawStall      = 1'b0;
    pendValid     = '0;
    rst_i         = 1'b1;
    flush_i       = 1'b0;
    stall_i       = 1'b0;
    fetchValid_i  = 1'b0;
    fetchVector_i = '0;
    fetch_i       = '0;
    repeat (16) @(negedge clk);
    rst_i = 1'b0;
    repeat (2) stepCycle(1'b0, 8'h00, 1'b0);

    testName = "decode and order";
    repeat (60) stepCycle(1'b1, 8'hFF, 1'b0);
    drain();

    testName = "sparse vectors";
    repeat (80) stepCycle(1'b1, 8'($random(seed)), 1'b0);
    drain();

    testName = "branch counting";
    repeat (40) stepCycle(1'b1, 8'($random(seed)), ($unsigned($random(seed)) % 4) == 0);
    drain();

    testName = "back-pressure";
    repeat (30) begin
      stepCycle(1'b1, 8'hFF, 1'b1);
      if (stallFetch_o) sawStall = 1'b1;
    end
    assert (sawStall)
      else failRun("Back-pressure: stallFetch_o never rose while stall_i was held high.");
    drain();

    testName = "flush";
    repeat (10) stepCycle(1'b1, 8'hFF, 1'b1);
    pulseFlush();
    pcNext = 32'h8000_0000;  // Post-flush stream lives in its own PC range.
    repeat (20) stepCycle(1'b1, 8'($random(seed)), 1'b0);
    drain();

    $display("Done: no errors");
    $finish;
  end

endmodule

/* decodeFrontEnd.f */
verilog/decodeQueuePkg.sv
verilog/multiPortRam.sv
verilog/preDecoder.sv
verilog/instructionBuffer.sv
verilog/decodeFrontEnd.sv
tests/decodeFrontEndTb.sv

/* Bender.yml */
package:
  name: decode_front_end

sources:
  # Design sources in compile order.
  - files:
      - verilog/decodeQueuePkg.sv
      - verilog/multiPortRam.sv
      - verilog/preDecoder.sv
      - verilog/instructionBuffer.sv
      - verilog/decodeFrontEnd.sv
  # Testbench, only for simulation.
  - target: test
    files:
      - tests/decodeFrontEndTb.sv
